// ==== build.f ====
verilog/exp16_pkg.sv
verilog/exp16_table_ram.sv
verilog/exp16_table_cfg.sv
verilog/exp16_range_reduce.sv
verilog/exp16_fp_mult.sv
verilog/exp16_recombine.sv
verilog/exp16_top.sv
test/tb_clock_gen.sv
test/exp16_asserts.sv
test/exp16_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the exp16 testbench with Verilator, result decided from sim.log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module exp16_tb \
    -f build.f -o exp16_sim > sim.log 2>&1 \
    && ./obj_dir/exp16_sim >> sim.log 2>&1 \
    || { echo "build or simulation failed, see sim.log"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; } \
    || grep -q "Done: no errors" sim.log && { echo "PASS"; exit 0; } \
    || { echo "FAIL, no result in sim.log"; exit 1; }

// ==== test/exp16_tb.sv ====
`default_nettype none

module exp16_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TOTAL_CYCLES = 512 * 8 + 64 * 12 + 40 + 2010 + 60 + 1010 + 64 * 24;

    logic             clk;
    logic             rst;
    logic             in_valid;
    exp16_pkg::fp16_t in_data;
    logic             out_valid;
    exp16_pkg::fp16_t out_data;
    logic             awvalid, awready, wvalid, wready, bvalid, bready;
    logic             arvalid, arready, rvalid, rready;
    logic [11:0]      awaddr, araddr;
    logic [31:0]      wdata, rdata;
    logic [3:0]       wstrb;
    logic [1:0]       bresp, rresp;

    logic [31:0] seed = 32'h1d9b;
    logic [15:0] int_tbl [256];
    logic [15:0] frac_tbl [256];
    int          exp_due [$];
    logic [15:0] exp_val [$];
    int          ncyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    string       cur_test;

    tb_clock_gen clkgen (.clk(clk), .rst(rst));

    exp16_top #(.AXIL_ADDR_W(12)) uut (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_data(in_data),
        .out_valid(out_valid), .out_data(out_data),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    bind exp16_top exp16_asserts chk (
        .clk(clk), .rst(rst), .in_valid(in_valid), .out_valid(out_valid),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .rvalid(rvalid), .rready(rready), .rdata(rdata)
    );

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[31:16], seed[15:0] ^ seed[31:16]};
    endfunction

    function automatic logic [15:0] rand_word(input int max_exp);
        logic [31:0] r;
        r = next_rand();
        return {r[20], 5'(1 + r[31:24] % max_exp), r[9:0]};
    endfunction

    function automatic logic [15:0] fp_mul(input logic [15:0] a, input logic [15:0] b);
        int unsigned pr;
        int          e;
        int          top;
        logic [9:0]  m;
        logic        s;
        s = a[15] ^ b[15];
        if (a[14:10] == 0 || b[14:10] == 0)
            return 16'h0000;
        pr  = (1024 + a[9:0]) * (1024 + b[9:0]);
        top = (pr >> 21) & 1;
        m   = (top == 1) ? 10'((pr >> 11) & 1023) : 10'((pr >> 10) & 1023);
        e   = a[14:10] + b[14:10] - 15 + top;
        if (e <= 0)
            return 16'h0000;
        if (e >= 31)
            return {s, 15'h7bff};
        return {s, 5'(e), m};
    endfunction

    function automatic logic [3:0] correction(input int rem);
        case (rem)
            0: return 4'd0;
            1: return 4'd1;
            2: return 4'd2;
            3: return 4'd4;
            4: return 4'd5;
            5: return 4'd6;
            6: return 4'd8;
            default: return 4'd10;
        endcase
    endfunction

    // e to the x from the model copies of both tables.
    function automatic logic [15:0] model_exp(input logic [15:0] x);
        logic        s;
        int          e, m, sh, ofs, ms;
        logic [7:0]  ii, fi;
        logic [15:0] p;
        s = x[15];
        e = x[14:10];
        m = x[9:0];
        if (!s && (e > 18 || (e == 18 && m > 395)))
            return 16'h7bff;
        if (s && (e > 18 || (e == 18 && m > 218)))
            return 16'h0400;
        if (e == 0)
        begin
            e = 1;
            m = 8;
        end
        sh = e - 15;
        case (sh)
            3: ofs = (m >> 7) & 3;
            2: ofs = (m >> 8) & 3;
            1: ofs = (m >> 9) & 1;
            default: ofs = 0;
        endcase
        ms = (sh >= 0) ? ((m << sh) & 1023) : (m >> (-sh));
        ii = {s, 2'(ofs), 5'(e)};
        fi = {s, 7'(ms >> 3)};
        p  = fp_mul(int_tbl[ii], frac_tbl[fi]);
        return s ? p - 16'(correction(ms & 7)) : p + 16'(correction(ms & 7));
    endfunction

    task automatic compare_word(input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        assert (actv === expv) else
        begin
            $display("ERR %s expected %h actual %h", cur_test, expv, actv);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else
        begin
            $display("%s: %s", cur_test, what);
            errors++;
        end
    endtask

    // expected results fall due three cycles after their operand.
    always @(negedge clk)
    begin
        if (!rst)
        begin
            ncyc++;
            if (out_valid)
            begin
                if (exp_due.size() == 0)
                begin
                    check_true(1'b0, "a result came out with no operand pending");
                end
                else
                begin
                    check_true(exp_due[0] == ncyc, "a result arrived at the wrong cycle");
                    compare_word(exp_val[0], out_data);
                    void'(exp_due.pop_front());
                    void'(exp_val.pop_front());
                end
            end
            else if (exp_due.size() > 0 && exp_due[0] <= ncyc)
            begin
                check_true(1'b0, "a result did not arrive at its due cycle");
                void'(exp_due.pop_front());
                void'(exp_val.pop_front());
            end
            if (in_valid)
            begin
                exp_due.push_back(ncyc + 3);
                exp_val.push_back(model_exp(in_data));
            end
        end
    end

    task automatic axi_write(input logic [11:0] addr, input logic [15:0] data,
                             input int hold, output logic [1:0] resp);
        logic [31:0] r;
        r = next_rand();
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= {r[31:16], data};
        do @(negedge clk); while (!awready);
        check_true(wready, "wready did not rise together with awready");
        @(posedge clk);
        // keep a second write waiting while the response is held.
        awvalid <= (hold > 0);
        wvalid  <= (hold > 0);
        repeat (hold)
        begin
            @(negedge clk);
            check_true(!awready && !wready,
                       "a write was accepted while a response was pending");
            @(posedge clk);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b1;
        do @(negedge clk); while (!bvalid);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= (hold > 0);
        repeat (hold)
        begin
            @(negedge clk);
            check_true(!arready, "a read was accepted while a response was pending");
            @(posedge clk);
        end
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic drive_operand(input logic valid, input logic [15:0] data);
        @(posedge clk);
        in_valid <= valid;
        in_data  <= data;
    endtask

    task automatic drain_results();
        drive_operand(1'b0, 16'h0000);
        while (exp_due.size() > 0)
            @(negedge clk);
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test();
        $display("test %s: %0d checks, %0d errors", cur_test,
                 checks - test_checks, errors - test_errors);
    endtask

    // writes one random entry and updates the model copy.
    task automatic write_entry(input int tbl, input int idx, input int hold);
        logic [15:0] w;
        logic [1:0]  resp;
        w = rand_word(30);
        axi_write(12'((tbl << 10) | (idx << 2)), w, hold, resp);
        compare_word(32'(exp16_pkg::OKAY), 32'(resp));
        if (tbl == 0)
            int_tbl[idx] = w;
        else
            frac_tbl[idx] = w;
    endtask

    task automatic read_entry(input int tbl, input int idx, input int hold);
        logic [31:0] d;
        logic [1:0]  resp;
        axi_read(12'((tbl << 10) | (idx << 2)), hold, d, resp);
        compare_word(32'(exp16_pkg::OKAY), 32'(resp));
        compare_word({16'h0000, (tbl == 0) ? int_tbl[idx] : frac_tbl[idx]}, d);
    endtask

    task automatic run_table_test();
        logic [31:0] d;
        logic [1:0]  resp;
        logic [11:0] bad;
        start_test("table_rw");
        for (int i = 0; i < 512; i++)
            write_entry(i / 256, i % 256, 0);
        for (int i = 0; i < 64; i++)
        begin
            d = next_rand();
            read_entry(d[8], d[7:0], 0);
        end
        d   = next_rand();
        bad = 12'h800 | 12'(d[8:0] << 2);
        axi_write(bad, 16'hffff, 0, resp);
        compare_word(32'(exp16_pkg::SLVERR), 32'(resp));
        axi_read(bad, 0, d, resp);
        compare_word(32'(exp16_pkg::SLVERR), 32'(resp));
        compare_word(32'h0, d);
        finish_test();
    endtask

    task automatic run_stream_test();
        start_test("stream");
        for (int i = 0; i < 2000; i++)
            drive_operand(1'b1, rand_word(17));
        drain_results();
        finish_test();
    endtask

    task automatic run_clamp_test();
        logic [15:0] ops [14];
        start_test("clamp_sat");
        ops = '{16'h7c00, 16'hfc00, 16'h7fff, {1'b0, 5'd18, 10'd395},
                {1'b0, 5'd18, 10'd396}, {1'b1, 5'd18, 10'd218}, {1'b1, 5'd18, 10'd219},
                {1'b0, 5'd19, 10'd0}, {1'b1, 5'd19, 10'd0}, 16'h0000, 16'h8000,
                16'h0005, 16'h83ff, {1'b0, 5'd18, 10'd394}};
        for (int i = 0; i < 14; i++)
            drive_operand(1'b1, ops[i]);
        drain_results();
        finish_test();
    endtask

    task automatic run_gap_test();
        logic [31:0] r;
        start_test("gapped");
        for (int i = 0; i < 1000; i++)
        begin
            r = next_rand();
            drive_operand(r[27], rand_word(18));
        end
        drain_results();
        finish_test();
    endtask

    task automatic run_backpressure_test();
        logic [31:0] r;
        start_test("axi_backpressure");
        for (int i = 0; i < 64; i++)
        begin
            r = next_rand();
            if (r[0])
                write_entry(r[9], r[17:10], r[31:24] % 9);
            else
                read_entry(r[9], r[17:10], r[31:24] % 9);
        end
        finish_test();
    endtask

    initial
    begin
        in_valid = 1'b0;
        in_data  = '0;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = 4'hf;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        @(negedge rst);
        run_table_test();
        run_stream_test();
        run_clamp_test();
        run_gap_test();
        run_backpressure_test();
        // failures of the bound concurrent assertions.
        errors += uut.chk.fail_count;
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        #(TOTAL_CYCLES * 2 * 10);
        $display("timeout: the tests did not finish in the expected time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/exp16_asserts.sv ====
`default_nettype none

module exp16_asserts (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic        in_valid,
    input wire logic        out_valid,
    input wire logic        bvalid,
    input wire logic        bready,
    input wire logic [1:0]  bresp,
    input wire logic        rvalid,
    input wire logic        rready,
    input wire logic [31:0] rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // out_valid follows in_valid by three cycles.
    latency_check: assert property (@(posedge clk)
        (!rst && !$past(rst, 3)) |-> (out_valid == $past(in_valid, 3)))
        else
        begin
            $error("out_valid does not follow in_valid by three cycles");
            fail_count++;
        end

    bresp_hold: assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else
        begin
            $error("write response dropped or changed before bready");
            fail_count++;
        end

    rdata_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else
        begin
            $error("read data dropped or changed before rready");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/exp16_top.sv ====
`default_nettype none

module exp16_top #(
    parameter int AXIL_ADDR_W = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  exp16_pkg::fp16_t        in_data,
    output logic                    out_valid,
    output exp16_pkg::fp16_t        out_data,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [AXIL_ADDR_W-1:0]  awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output exp16_pkg::axil_resp_t   bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [AXIL_ADDR_W-1:0]  araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [31:0]             rdata,
    output exp16_pkg::axil_resp_t   rresp
);

    logic                lk_valid;
    exp16_pkg::lookup_t  lk;
    exp16_pkg::recomb_t  rc;
    exp16_pkg::fp16_t    int_word;
    exp16_pkg::fp16_t    frac_word;
    logic                int_we;
    logic                frac_we;
    exp16_pkg::tbl_idx_t cfg_addr;
    exp16_pkg::fp16_t    cfg_wdata;
    exp16_pkg::fp16_t    int_rdata;
    exp16_pkg::fp16_t    frac_rdata;

    exp16_range_reduce u_range_reduce (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .lk_valid (lk_valid),
        .lk       (lk)
    );

    // table indices go to the rams, the rest rides along.
    assign rc = '{sign: lk.sign, correction: lk.correction,
                  sat_pos: lk.sat_pos, sat_neg: lk.sat_neg};

    exp16_table_ram int_ram (
        .clk       (clk),
        .cfg_addr  (cfg_addr),
        .cfg_we    (int_we),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (int_rdata),
        .lk_addr   (lk.int_idx),
        .lk_rdata  (int_word)
    );

    exp16_table_ram frac_ram (
        .clk       (clk),
        .cfg_addr  (cfg_addr),
        .cfg_we    (frac_we),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (frac_rdata),
        .lk_addr   (lk.frac_idx),
        .lk_rdata  (frac_word)
    );

    exp16_table_cfg #(
        .AXIL_ADDR_W (AXIL_ADDR_W)
    ) u_table_cfg (
        .clk        (clk),
        .rst        (rst),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .int_we     (int_we),
        .frac_we    (frac_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .int_rdata  (int_rdata),
        .frac_rdata (frac_rdata)
    );

    exp16_recombine u_recombine (
        .clk       (clk),
        .rst       (rst),
        .lk_valid  (lk_valid),
        .rc        (rc),
        .int_word  (int_word),
        .frac_word (frac_word),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

// ==== verilog/exp16_recombine.sv ====
`default_nettype none

module exp16_recombine (
    input  logic               clk,
    input  logic               rst,
    input  logic               lk_valid,
    input  exp16_pkg::recomb_t rc,
    input  exp16_pkg::fp16_t   int_word,
    input  exp16_pkg::fp16_t   frac_word,
    output logic               out_valid,
    output exp16_pkg::fp16_t   out_data
);

    logic               valid_q;
    exp16_pkg::recomb_t rc_q;
    exp16_pkg::fp16_t   prod;
    logic [15:0]        result;

    exp16_fp_mult u_mult (
        .a (int_word),
        .b (frac_word),
        .p (prod)
    );

    // line up with the table read.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            valid_q   <= lk_valid;
            out_valid <= valid_q;
        end
    end

    always_comb
    begin
        if (rc_q.sat_pos)
            result = exp16_pkg::FP16_MAX_FINITE;
        else if (rc_q.sat_neg)
            result = exp16_pkg::FP16_MIN_NORMAL;
        else if (rc_q.sign)
            result = prod - {12'h000, rc_q.correction};
        else
            result = prod + {12'h000, rc_q.correction};
    end

    always_ff @(posedge clk)
    begin
        rc_q     <= rc;
        out_data <= result;
    end

endmodule

`default_nettype wire

// ==== verilog/exp16_fp_mult.sv ====
`default_nettype none

module exp16_fp_mult (
    input  exp16_pkg::fp16_t a,
    input  exp16_pkg::fp16_t b,
    output exp16_pkg::fp16_t p
);

    logic              sign;
    logic              zero_in;
    logic [10:0]       sig_a;
    logic [10:0]       sig_b;
    logic [21:0]       prod;
    logic [9:0]        mant;
    logic signed [7:0] exp_sum;

    assign sign    = a.sign ^ b.sign;
    assign zero_in = (a.exponent == 5'd0) || (b.exponent == 5'd0);
    assign sig_a   = {1'b1, a.mantissa};
    assign sig_b   = {1'b1, b.mantissa};
    assign prod    = sig_a * sig_b;

    // product lies in [1, 4), top bit set means one extra exponent step.
    assign mant    = prod[21] ? prod[20:11] : prod[19:10];
    assign exp_sum = 8'(a.exponent) + 8'(b.exponent)
                   - 8'(exp16_pkg::FP16_BIAS) + 8'(prod[21]);

    always_comb
    begin
        if (zero_in || exp_sum <= 0)
        begin
            p = '0;
        end
        else if (exp_sum >= 31)
        begin
            p          = exp16_pkg::FP16_MAX_FINITE;
            p.sign     = sign;
        end
        else
        begin
            p.sign     = sign;
            p.exponent = exp_sum[4:0];
            p.mantissa = mant;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exp16_range_reduce.sv ====
`default_nettype none

module exp16_range_reduce (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  exp16_pkg::fp16_t   in_data,
    output logic               lk_valid,
    output exp16_pkg::lookup_t lk
);

    exp16_pkg::fp16_t  op_q;
    logic              valid_q;
    logic [14:0]       mag;
    logic [4:0]        exponent;
    logic [9:0]        mantissa;
    logic signed [5:0] shift;
    logic [5:0]        shift_abs;
    logic [1:0]        offset;
    logic [9:0]        mant_shift;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            op_q <= in_data;
        end
    end

    // clamp large and subnormal inputs.
    always_comb
    begin
        mag = {op_q.exponent, op_q.mantissa};
        if (!op_q.sign && mag > exp16_pkg::POS_CLAMP_LIMIT)
            mag = exp16_pkg::POS_CLAMP_VALUE;
        else if (op_q.sign && mag > exp16_pkg::NEG_CLAMP_LIMIT)
            mag = exp16_pkg::NEG_CLAMP_VALUE;
        else if (op_q.exponent == 5'd0)
            mag = exp16_pkg::SUBNORMAL_VALUE;
    end

    assign exponent  = mag[14:10];
    assign mantissa  = mag[9:0];
    assign shift     = 6'($signed({1'b0, exponent}) - exp16_pkg::FP16_BIAS);
    assign shift_abs = 6'(-shift);

    // integer bits of the operand that sit in the mantissa.
    always_comb
    begin
        case (shift)
            6'sd3:   offset = mantissa[8:7];
            6'sd2:   offset = mantissa[9:8];
            6'sd1:   offset = {1'b0, mantissa[9]};
            default: offset = 2'b00;
        endcase
    end

    always_comb
    begin
        if (shift >= 0)
            mant_shift = mantissa << shift;
        else
            mant_shift = mantissa >> shift_abs;
    end

    assign lk_valid      = valid_q;
    assign lk.sign       = op_q.sign;
    assign lk.int_idx    = {op_q.sign, offset, exponent};
    assign lk.frac_idx   = {op_q.sign, mant_shift[9:3]};
    assign lk.correction = exp16_pkg::CORRECTION_TABLE[mant_shift[2:0]];
    assign lk.sat_pos    = !op_q.sign
                         && (op_q.exponent > exp16_pkg::SAT_EXPONENT
                         || (op_q.exponent == exp16_pkg::SAT_EXPONENT
                         && op_q.mantissa > exp16_pkg::POS_SAT_MANTISSA));
    assign lk.sat_neg    = op_q.sign
                         && (op_q.exponent > exp16_pkg::SAT_EXPONENT
                         || (op_q.exponent == exp16_pkg::SAT_EXPONENT
                         && op_q.mantissa > exp16_pkg::NEG_SAT_MANTISSA));

endmodule

`default_nettype wire

// ==== verilog/exp16_table_cfg.sv ====
`default_nettype none

module exp16_table_cfg #(
    parameter int AXIL_ADDR_W = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [AXIL_ADDR_W-1:0]  awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output exp16_pkg::axil_resp_t   bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [AXIL_ADDR_W-1:0]  araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [31:0]             rdata,
    output exp16_pkg::axil_resp_t   rresp,
    output logic                    int_we,
    output logic                    frac_we,
    output exp16_pkg::tbl_idx_t     cfg_addr,
    output exp16_pkg::fp16_t        cfg_wdata,
    input  exp16_pkg::fp16_t        int_rdata,
    input  exp16_pkg::fp16_t        frac_rdata
);

    logic             wr_req;
    logic             wr_accept;
    logic             ar_accept;
    logic             aw_map;
    logic             ar_map;
    logic             rd_pend;
    logic             rd_sel;
    logic             rd_err;
    exp16_pkg::fp16_t rd_word;

    // byte address, word bits [9:2], table select bit 10.
    function automatic logic addr_mapped(input logic [AXIL_ADDR_W-1:0] addr);
        return (addr >> 11) == '0;
    endfunction

    assign aw_map = addr_mapped(awaddr);
    assign ar_map = addr_mapped(araddr);

    assign ar_accept = arvalid && arready;
    assign wr_req    = awvalid && wvalid && !bvalid;
    // reads win the shared table port.
    assign wr_accept = wr_req && !ar_accept;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign cfg_addr  = ar_accept ? araddr[9:2] : awaddr[9:2];
    assign cfg_wdata = wdata[15:0];
    assign int_we    = wr_accept && aw_map && !awaddr[10];
    assign frac_we   = wr_accept && aw_map && awaddr[10];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bvalid <= 1'b0;
        end
        else if (wr_accept)
        begin
            bvalid <= 1'b1;
        end
        else if (bready)
        begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            bresp <= aw_map ? exp16_pkg::OKAY : exp16_pkg::SLVERR;
        end
    end

    // ram data is back one cycle after acceptance.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_pend <= 1'b0;
            rvalid  <= 1'b0;
            arready <= 1'b0;
        end
        else
        begin
            rd_pend <= ar_accept;
            if (rd_pend)
            begin
                rvalid <= 1'b1;
            end
            else if (rready)
            begin
                rvalid <= 1'b0;
            end
            arready <= !ar_accept && !rd_pend && !(rvalid && !rready);
        end
    end

    assign rd_word = rd_sel ? frac_rdata : int_rdata;

    always_ff @(posedge clk)
    begin
        if (ar_accept)
        begin
            rd_sel <= araddr[10];
            rd_err <= !ar_map;
        end
        if (rd_pend)
        begin
            rdata <= rd_err ? 32'h0 : {16'h0000, rd_word};
            rresp <= rd_err ? exp16_pkg::SLVERR : exp16_pkg::OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exp16_table_ram.sv ====
`default_nettype none

module exp16_table_ram (
    input  logic                clk,
    input  exp16_pkg::tbl_idx_t cfg_addr,
    input  logic                cfg_we,
    input  exp16_pkg::fp16_t    cfg_wdata,
    output exp16_pkg::fp16_t    cfg_rdata,
    input  exp16_pkg::tbl_idx_t lk_addr,
    output exp16_pkg::fp16_t    lk_rdata
);

    exp16_pkg::fp16_t mem [256];

    // configuration port, write and registered readback.
    always_ff @(posedge clk)
    begin
        if (cfg_we)
        begin
            mem[cfg_addr] <= cfg_wdata;
        end
        cfg_rdata <= mem[cfg_addr];
    end

    // lookup port.
    always_ff @(posedge clk)
    begin
        lk_rdata <= mem[lk_addr];
    end

endmodule

`default_nettype wire

// ==== verilog/exp16_pkg.sv ====
`default_nettype none

package exp16_pkg;

    typedef struct packed {
        logic       sign;
        logic [4:0] exponent;
        logic [9:0] mantissa;
    } fp16_t;

    localparam int FP16_BIAS = 15;

    localparam fp16_t FP16_MAX_FINITE = '{sign: 1'b0, exponent: 5'd30, mantissa: 10'h3ff};
    localparam fp16_t FP16_MIN_NORMAL = '{sign: 1'b0, exponent: 5'd1, mantissa: 10'd0};

    // magnitudes as {exponent, mantissa}.
    localparam logic [14:0] POS_CLAMP_LIMIT = {5'd18, 10'd395};
    localparam logic [14:0] POS_CLAMP_VALUE = {5'd18, 10'd396};
    localparam logic [14:0] NEG_CLAMP_LIMIT = {5'd18, 10'd218};
    localparam logic [14:0] NEG_CLAMP_VALUE = {5'd18, 10'd219};
    localparam logic [14:0] SUBNORMAL_VALUE = {5'd1, 10'd8};

    localparam logic [4:0] SAT_EXPONENT     = 5'd18;
    localparam logic [9:0] POS_SAT_MANTISSA = 10'd395;
    localparam logic [9:0] NEG_SAT_MANTISSA = 10'd218;

    // indexed by the three bits shifted out below the fraction index.
    localparam logic [3:0] CORRECTION_TABLE [8] = '{
        4'd0, 4'd1, 4'd2, 4'd4, 4'd5, 4'd6, 4'd8, 4'd10
    };

    typedef logic [7:0] tbl_idx_t;

    typedef struct packed {
        logic       sign;
        tbl_idx_t   int_idx;
        tbl_idx_t   frac_idx;
        logic [3:0] correction;
        logic       sat_pos;
        logic       sat_neg;
    } lookup_t;

    typedef struct packed {
        logic       sign;
        logic [3:0] correction;
        logic       sat_pos;
        logic       sat_neg;
    } recomb_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

endpackage

`default_nettype wire
